//--- msg_consts.svh
`ifndef MSG_CONSTS_SVH
`define MSG_CONSTS_SVH

// payload width of every message
`define NS_DATA_SIZE 8

// check field is the xor of the two payload nibbles
`define NS_CHECK_SIZE 4

// message counts per source, up to 63
`define NS_COUNT_SIZE 6

// first payload sent by each source
`define NS_BASE_0 0
`define NS_BASE_1 23

// message index whose check field gets inverted when corruption is on
`define NS_CORRUPT_IDX 2

`endif

//--- msg_pkg.sv
`default_nettype none

`include "msg_consts.svh"

package msg_pkg;

	// message opcode carried on every link
	typedef enum logic {
		MSG_DATA = 1'b0,
		MSG_LAST = 1'b1
	} msg_kind_e;

	// source sequencer
	typedef enum logic [1:0] {
		SRC_IDLE = 2'd0,
		SRC_SEND = 2'd1,
		SRC_DONE = 2'd2
	} src_state_e;

	// merge output slot
	typedef enum logic {
		ARB_EMPTY = 1'b0,
		ARB_FULL  = 1'b1
	} arb_state_e;

	// check bits of a payload, shared by sender and checker
	function automatic logic [`NS_CHECK_SIZE-1:0] calc_chk(
		input logic [`NS_DATA_SIZE-1:0] dat
	);
		return dat[`NS_DATA_SIZE-1:`NS_CHECK_SIZE] ^ dat[`NS_CHECK_SIZE-1:0];
	endfunction

endpackage

`default_nettype wire

//--- msg_source.sv
`timescale 1ns/1ps
`default_nettype none

`include "msg_consts.svh"

module msg_source #(
	parameter int BASE   = 0,
	parameter int SRC_ID = 0
) (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire                         i_start,
	input  wire  [`NS_COUNT_SIZE-1:0]   i_count,
	input  wire                         i_corrupt,
	output logic                        o_req,
	input  wire                         i_ack,
	output logic [`NS_DATA_SIZE-1:0]    o_dat,
	output logic [`NS_CHECK_SIZE-1:0]   o_chk,
	output msg_pkg::msg_kind_e          o_kind,
	output logic                        o_src
);

	msg_pkg::src_state_e state_q;

	// index of the message on offer, from zero
	logic [`NS_COUNT_SIZE-1:0] idx_q;
	logic [`NS_COUNT_SIZE-1:0] count_q;
	logic                      corrupt_q;

	logic                      last_w;
	logic                      bad_w;
	logic [`NS_DATA_SIZE-1:0]  dat_w;

	assign last_w = ((idx_q + 1'b1) == count_q);
	assign bad_w  = corrupt_q && (idx_q == `NS_COUNT_SIZE'(`NS_CORRUPT_IDX));
	assign dat_w  = `NS_DATA_SIZE'(BASE) + `NS_DATA_SIZE'(idx_q);

	// fields come straight from registers so they hold while stalled
	assign o_req  = (state_q == msg_pkg::SRC_SEND);
	assign o_dat  = dat_w;
	assign o_chk  = msg_pkg::calc_chk(dat_w) ^ {`NS_CHECK_SIZE{bad_w}};
	assign o_kind = last_w ? msg_pkg::MSG_LAST : msg_pkg::MSG_DATA;
	assign o_src  = SRC_ID[0];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q   <= msg_pkg::SRC_IDLE;
			idx_q     <= '0;
			count_q   <= '0;
			corrupt_q <= 1'b0;
		end else if (i_start) begin
			// run length and corruption are fixed for the whole run
			state_q   <= msg_pkg::SRC_SEND;
			idx_q     <= '0;
			count_q   <= i_count;
			corrupt_q <= i_corrupt;
		end else begin
			case (state_q)
				msg_pkg::SRC_SEND: begin
					if (i_ack) begin
						if (last_w) begin
							state_q <= msg_pkg::SRC_DONE;
						end else begin
							idx_q <= idx_q + 1'b1;
						end
					end
				end
				msg_pkg::SRC_DONE: begin
					// waits here for the next start
					state_q <= msg_pkg::SRC_DONE;
				end
				default: begin
					state_q <= msg_pkg::SRC_IDLE;
				end
			endcase
		end
	end

	// an offered message may not change or vanish before it is taken
	property p_offer_held;
		@(posedge i_clk) disable iff (!i_rst_n)
		(o_req && !i_ack && !i_start) |=>
			(o_req && $stable(o_dat) && $stable(o_chk) && $stable(o_kind) && $stable(o_src));
	endproperty

	a_offer_held : assert property (p_offer_held);

endmodule

`default_nettype wire

//--- msg_merge_2to1.sv
`timescale 1ns/1ps
`default_nettype none

`include "msg_consts.svh"

module msg_merge_2to1 (
	input  wire                         i_clk,
	input  wire                         i_rst_n,

	input  wire                         i_req_0,
	output logic                        o_ack_0,
	input  wire  [`NS_DATA_SIZE-1:0]    i_dat_0,
	input  wire  [`NS_CHECK_SIZE-1:0]   i_chk_0,
	input  wire  msg_pkg::msg_kind_e    i_kind_0,
	input  wire                         i_src_0,

	input  wire                         i_req_1,
	output logic                        o_ack_1,
	input  wire  [`NS_DATA_SIZE-1:0]    i_dat_1,
	input  wire  [`NS_CHECK_SIZE-1:0]   i_chk_1,
	input  wire  msg_pkg::msg_kind_e    i_kind_1,
	input  wire                         i_src_1,

	output logic                        o_req,
	input  wire                         i_ack,
	output logic [`NS_DATA_SIZE-1:0]    o_dat,
	output logic [`NS_CHECK_SIZE-1:0]   o_chk,
	output msg_pkg::msg_kind_e          o_kind,
	output logic                        o_src
);

	msg_pkg::arb_state_e state_q;

	// high when input 1 won the last grant
	logic last_gnt_q;

	logic slot_free;
	logic gnt_0;
	logic gnt_1;

	logic [`NS_DATA_SIZE-1:0]  dat_q;
	logic [`NS_CHECK_SIZE-1:0] chk_q;
	msg_pkg::msg_kind_e        kind_q;
	logic                      src_q;

	assign o_req = (state_q == msg_pkg::ARB_FULL);

	// a full slot draining this cycle can take a new message at once
	assign slot_free = !o_req || i_ack;

	assign gnt_0 = slot_free && i_req_0 && (!i_req_1 || last_gnt_q);
	assign gnt_1 = slot_free && i_req_1 && (!i_req_0 || !last_gnt_q);

	assign o_ack_0 = gnt_0;
	assign o_ack_1 = gnt_1;

	assign o_dat  = dat_q;
	assign o_chk  = chk_q;
	assign o_kind = kind_q;
	assign o_src  = src_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q    <= msg_pkg::ARB_EMPTY;
			// input 0 wins the first tie
			last_gnt_q <= 1'b1;
		end else if (gnt_0 || gnt_1) begin
			state_q    <= msg_pkg::ARB_FULL;
			last_gnt_q <= gnt_1;
		end else if (o_req && i_ack) begin
			state_q    <= msg_pkg::ARB_EMPTY;
		end
	end

	// slot payload
	always_ff @(posedge i_clk) begin
		if (gnt_0) begin
			dat_q  <= i_dat_0;
			chk_q  <= i_chk_0;
			kind_q <= i_kind_0;
			src_q  <= i_src_0;
		end else if (gnt_1) begin
			dat_q  <= i_dat_1;
			chk_q  <= i_chk_1;
			kind_q <= i_kind_1;
			src_q  <= i_src_1;
		end
	end

	a_one_grant : assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_ack_0 && o_ack_1));

endmodule

`default_nettype wire

//--- msg_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "msg_consts.svh"

module msg_checker (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire                         i_start,
	input  wire                         i_hold,
	input  wire                         i_req,
	output logic                        o_ack,
	input  wire  [`NS_DATA_SIZE-1:0]    i_dat,
	input  wire  [`NS_CHECK_SIZE-1:0]   i_chk,
	input  wire  msg_pkg::msg_kind_e    i_kind,
	input  wire                         i_src,
	output logic                        o_done,
	output logic                        o_err_0,
	output logic                        o_err_1,
	output logic [`NS_COUNT_SIZE:0]     o_total,
	output logic [`NS_DATA_SIZE-1:0]    o_fst_err_dat,
	output logic [`NS_DATA_SIZE-1:0]    o_last_dat_0
);

	// next payload expected from each source
	logic [`NS_DATA_SIZE-1:0] exp_0_q;
	logic [`NS_DATA_SIZE-1:0] exp_1_q;

	logic last_0_q;
	logic last_1_q;
	logic fst_vld_q;

	logic                     xfer;
	logic                     bad_w;
	logic [`NS_DATA_SIZE-1:0] exp_w;

	assign o_ack = !i_hold;
	assign xfer  = i_req && o_ack;

	assign exp_w = i_src ? exp_1_q : exp_0_q;
	assign bad_w = (i_chk != msg_pkg::calc_chk(i_dat)) || (i_dat != exp_w);

	// high from the cycle after the later last message
	assign o_done = last_0_q && last_1_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			exp_0_q       <= `NS_DATA_SIZE'(`NS_BASE_0);
			exp_1_q       <= `NS_DATA_SIZE'(`NS_BASE_1);
			last_0_q      <= 1'b0;
			last_1_q      <= 1'b0;
			fst_vld_q     <= 1'b0;
			o_err_0       <= 1'b0;
			o_err_1       <= 1'b0;
			o_total       <= '0;
			o_fst_err_dat <= '0;
		end else if (i_start) begin
			exp_0_q       <= `NS_DATA_SIZE'(`NS_BASE_0);
			exp_1_q       <= `NS_DATA_SIZE'(`NS_BASE_1);
			last_0_q      <= 1'b0;
			last_1_q      <= 1'b0;
			fst_vld_q     <= 1'b0;
			o_err_0       <= 1'b0;
			o_err_1       <= 1'b0;
			o_total       <= '0;
			o_fst_err_dat <= '0;
		end else if (xfer) begin
			o_total <= o_total + 1'b1;
			if (i_src) begin
				exp_1_q <= exp_1_q + 1'b1;
				if (bad_w) begin
					o_err_1 <= 1'b1;
				end
				if (i_kind == msg_pkg::MSG_LAST) begin
					last_1_q <= 1'b1;
				end
			end else begin
				exp_0_q <= exp_0_q + 1'b1;
				if (bad_w) begin
					o_err_0 <= 1'b1;
				end
				if (i_kind == msg_pkg::MSG_LAST) begin
					last_0_q <= 1'b1;
				end
			end
			// only the first bad message of a run is kept
			if (bad_w && !fst_vld_q) begin
				fst_vld_q     <= 1'b1;
				o_fst_err_dat <= i_dat;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_last_dat_0 <= '0;
		end else if (xfer && !i_src) begin
			o_last_dat_0 <= i_dat;
		end
	end

	a_total_grows : assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_start |=> (o_total >= $past(o_total)));

endmodule

`default_nettype wire

//--- seg_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "msg_consts.svh"

module seg_display (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire                         i_show,
	input  wire                         i_err,
	input  wire  [`NS_DATA_SIZE-1:0]    i_err_dat,
	input  wire  [`NS_DATA_SIZE-1:0]    i_ok_dat,
	output logic [6:0]                  o_seg_hi,
	output logic [6:0]                  o_seg_lo
);

	logic                     show_q;
	logic [`NS_DATA_SIZE-1:0] disp_q;
	logic                     show_rise;

	// segment bits are {g, f, e, d, c, b, a}, high means lit
	function automatic logic [6:0] hex_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'h3f;
			4'h1: return 7'h06;
			4'h2: return 7'h5b;
			4'h3: return 7'h4f;
			4'h4: return 7'h66;
			4'h5: return 7'h6d;
			4'h6: return 7'h7d;
			4'h7: return 7'h07;
			4'h8: return 7'h7f;
			4'h9: return 7'h6f;
			4'ha: return 7'h77;
			// lower case b
			4'hb: return 7'h7c;
			4'hc: return 7'h39;
			// lower case d
			4'hd: return 7'h5e;
			4'he: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	assign show_rise = i_show && !show_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			show_q <= 1'b0;
			disp_q <= '0;
		end else begin
			show_q <= i_show;
			if (show_rise) begin
				disp_q <= i_err ? i_err_dat : i_ok_dat;
			end
		end
	end

	// board digits are active low
	assign o_seg_hi = ~hex_seg(disp_q[`NS_DATA_SIZE-1:`NS_DATA_SIZE/2]);
	assign o_seg_lo = ~hex_seg(disp_q[`NS_DATA_SIZE/2-1:0]);

endmodule

`default_nettype wire

//--- msg_test_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "msg_consts.svh"

module msg_test_top (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire                         i_start,
	input  wire  [`NS_COUNT_SIZE-1:0]   i_count_0,
	input  wire  [`NS_COUNT_SIZE-1:0]   i_count_1,
	input  wire                         i_corrupt_0,
	input  wire                         i_corrupt_1,
	input  wire                         i_hold,
	input  wire                         i_show,
	output logic                        o_done,
	output logic                        o_err_0,
	output logic                        o_err_1,
	output logic [`NS_COUNT_SIZE:0]     o_total,
	output logic [`NS_DATA_SIZE-1:0]    o_fst_err_dat,
	output logic [6:0]                  o_seg_hi,
	output logic [6:0]                  o_seg_lo
);

	// source 0 to merge
	logic                      s0_req;
	logic                      s0_ack;
	logic [`NS_DATA_SIZE-1:0]  s0_dat;
	logic [`NS_CHECK_SIZE-1:0] s0_chk;
	msg_pkg::msg_kind_e        s0_kind;
	logic                      s0_src;

	// source 1 to merge
	logic                      s1_req;
	logic                      s1_ack;
	logic [`NS_DATA_SIZE-1:0]  s1_dat;
	logic [`NS_CHECK_SIZE-1:0] s1_chk;
	msg_pkg::msg_kind_e        s1_kind;
	logic                      s1_src;

	// merge to checker
	logic                      m_req;
	logic                      m_ack;
	logic [`NS_DATA_SIZE-1:0]  m_dat;
	logic [`NS_CHECK_SIZE-1:0] m_chk;
	msg_pkg::msg_kind_e        m_kind;
	logic                      m_src;

	logic [`NS_DATA_SIZE-1:0]  last_dat_0;

	msg_source #(.BASE(`NS_BASE_0), .SRC_ID(0)) i_src_0 (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
		.i_count(i_count_0), .i_corrupt(i_corrupt_0),
		.o_req(s0_req), .i_ack(s0_ack), .o_dat(s0_dat),
		.o_chk(s0_chk), .o_kind(s0_kind), .o_src(s0_src)
	);

	msg_source #(.BASE(`NS_BASE_1), .SRC_ID(1)) i_src_1 (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
		.i_count(i_count_1), .i_corrupt(i_corrupt_1),
		.o_req(s1_req), .i_ack(s1_ack), .o_dat(s1_dat),
		.o_chk(s1_chk), .o_kind(s1_kind), .o_src(s1_src)
	);

	msg_merge_2to1 i_msg_merge (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_req_0(s0_req), .o_ack_0(s0_ack), .i_dat_0(s0_dat),
		.i_chk_0(s0_chk), .i_kind_0(s0_kind), .i_src_0(s0_src),
		.i_req_1(s1_req), .o_ack_1(s1_ack), .i_dat_1(s1_dat),
		.i_chk_1(s1_chk), .i_kind_1(s1_kind), .i_src_1(s1_src),
		.o_req(m_req), .i_ack(m_ack), .o_dat(m_dat),
		.o_chk(m_chk), .o_kind(m_kind), .o_src(m_src)
	);

	msg_checker i_msg_checker (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_hold(i_hold),
		.i_req(m_req), .o_ack(m_ack), .i_dat(m_dat),
		.i_chk(m_chk), .i_kind(m_kind), .i_src(m_src),
		.o_done(o_done), .o_err_0(o_err_0), .o_err_1(o_err_1),
		.o_total(o_total), .o_fst_err_dat(o_fst_err_dat), .o_last_dat_0(last_dat_0)
	);

	// shows the first bad byte after a source 0 error, else its last payload
	seg_display i_seg_display (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_show(i_show),
		.i_err(o_err_0), .i_err_dat(o_fst_err_dat), .i_ok_dat(last_dat_0),
		.o_seg_hi(o_seg_hi), .o_seg_lo(o_seg_lo)
	);

endmodule

`default_nettype wire

//--- tb_msg_test_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "msg_consts.svh"

module tb_msg_test_top;

	localparam int MAX_CASES = 32;
	localparam int FIELDS    = 8;

	logic                       i_clk = 1'b0;
	logic                       i_rst_n;
	logic                       i_start;
	logic [`NS_COUNT_SIZE-1:0]  i_count_0;
	logic [`NS_COUNT_SIZE-1:0]  i_count_1;
	logic                       i_corrupt_0;
	logic                       i_corrupt_1;
	logic                       i_hold;
	logic                       i_show;
	logic                       o_done;
	logic                       o_err_0;
	logic                       o_err_1;
	logic [`NS_COUNT_SIZE:0]    o_total;
	logic [`NS_DATA_SIZE-1:0]   o_fst_err_dat;
	logic [6:0]                 o_seg_hi;
	logic [6:0]                 o_seg_lo;

	// FIELDS bytes per case, in file column order
	logic [7:0] case_mem [0:MAX_CASES*FIELDS-1];

	int n_cases;
	int err_cnt;
	int chk_cnt;
	int cycle_cnt;
	int cycle_limit;

	msg_test_top i_msg_test_top (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
		.i_count_0(i_count_0), .i_count_1(i_count_1),
		.i_corrupt_0(i_corrupt_0), .i_corrupt_1(i_corrupt_1),
		.i_hold(i_hold), .i_show(i_show),
		.o_done(o_done), .o_err_0(o_err_0), .o_err_1(o_err_1),
		.o_total(o_total), .o_fst_err_dat(o_fst_err_dat),
		.o_seg_hi(o_seg_hi), .o_seg_lo(o_seg_lo)
	);

	always #4 i_clk = ~i_clk;

	// hang guard, limit is set once the cases are known
	always @(posedge i_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("run hung: o_done did not arrive within %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// lit segments of each hex digit
	function automatic string seg_letters(input logic [3:0] nib);
		case (nib)
			4'h0: return "abcdef";
			4'h1: return "bc";
			4'h2: return "abdeg";
			4'h3: return "abcdg";
			4'h4: return "bcfg";
			4'h5: return "acdfg";
			4'h6: return "acdefg";
			4'h7: return "abc";
			4'h8: return "abcdefg";
			4'h9: return "abcdfg";
			4'ha: return "abcefg";
			4'hb: return "cdefg";
			4'hc: return "adef";
			4'hd: return "bcdeg";
			4'he: return "adefg";
			default: return "aefg";
		endcase
	endfunction

	// active low, segment a on bit 0
	function automatic logic [6:0] seg_expect(input logic [3:0] nib);
		string      s;
		logic [6:0] lit;
		int         i;
		s = seg_letters(nib);
		lit = '0;
		for (i = 0; i < s.len(); i++) begin
			lit[s[i] - "a"] = 1'b1;
		end
		return ~lit;
	endfunction

	task automatic run_case(input int idx);
		logic [7:0] cnt_0;
		logic [7:0] cnt_1;
		logic [7:0] exp_total;
		logic       cor_0;
		logic       cor_1;
		logic       hold_mode;
		logic       exp_err_0;
		logic       exp_err_1;
		logic [7:0] shown;
		cnt_0     = case_mem[idx*FIELDS+0];
		cnt_1     = case_mem[idx*FIELDS+1];
		cor_0     = case_mem[idx*FIELDS+2][0];
		cor_1     = case_mem[idx*FIELDS+3][0];
		hold_mode = case_mem[idx*FIELDS+4][0];
		exp_err_0 = case_mem[idx*FIELDS+5][0];
		exp_err_1 = case_mem[idx*FIELDS+6][0];
		exp_total = case_mem[idx*FIELDS+7];
		if ((cor_0 && cor_1) || (cor_0 && cnt_0 <= `NS_CORRUPT_IDX) ||
				(cor_1 && cnt_1 <= `NS_CORRUPT_IDX)) begin
			$display("case %0d cannot be used: corrupted run is too short or both corrupt", idx);
			err_cnt++;
		end
		@(posedge i_clk);
		i_count_0   <= cnt_0[`NS_COUNT_SIZE-1:0];
		i_count_1   <= cnt_1[`NS_COUNT_SIZE-1:0];
		i_corrupt_0 <= cor_0;
		i_corrupt_1 <= cor_1;
		i_start     <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
		@(negedge i_clk);
		// start wipes the previous run
		check_value(o_done, 0, $sformatf("case %0d o_done after start", idx));
		check_value(o_err_0, 0, $sformatf("case %0d o_err_0 after start", idx));
		check_value(o_err_1, 0, $sformatf("case %0d o_err_1 after start", idx));
		check_value(o_total, 0, $sformatf("case %0d o_total after start", idx));
		while (o_done !== 1'b1) begin
			@(posedge i_clk);
			if (hold_mode) begin
				i_hold <= (($urandom % 3) == 0);
			end
			@(negedge i_clk);
		end
		// first cycle of o_done, so the count must be complete already
		check_value(o_total, exp_total, $sformatf("case %0d o_total at done", idx));
		check_value(o_err_0, exp_err_0, $sformatf("case %0d o_err_0", idx));
		check_value(o_err_1, exp_err_1, $sformatf("case %0d o_err_1", idx));
		if (cor_0) begin
			check_value(o_fst_err_dat, `NS_BASE_0 + `NS_CORRUPT_IDX,
				$sformatf("case %0d o_fst_err_dat", idx));
		end else if (cor_1) begin
			check_value(o_fst_err_dat, `NS_BASE_1 + `NS_CORRUPT_IDX,
				$sformatf("case %0d o_fst_err_dat", idx));
		end
		@(posedge i_clk);
		i_hold <= 1'b0;
		i_show <= 1'b1;
		@(posedge i_clk);
		@(negedge i_clk);
		shown = cor_0 ? (`NS_BASE_0 + `NS_CORRUPT_IDX) : (`NS_BASE_0 + cnt_0 - 1);
		check_value(o_seg_hi, seg_expect(shown[7:4]), $sformatf("case %0d o_seg_hi", idx));
		check_value(o_seg_lo, seg_expect(shown[3:0]), $sformatf("case %0d o_seg_lo", idx));
		@(posedge i_clk);
		i_show <= 1'b0;
	endtask

	initial begin
		int unsigned seed;
		int          msgs;
		int          k;
		seed = 32'h20bb_a371;
		void'($urandom(seed));
		i_rst_n     <= 1'b0;
		i_start     <= 1'b0;
		i_count_0   <= '0;
		i_count_1   <= '0;
		i_corrupt_0 <= 1'b0;
		i_corrupt_1 <= 1'b0;
		i_hold      <= 1'b0;
		i_show      <= 1'b0;
		for (k = 0; k < MAX_CASES*FIELDS; k++) begin
			case_mem[k] = '0;
		end
		$readmemh("msg_cases.txt", case_mem);
		// a zero count_0 ends the list
		n_cases = 0;
		msgs = 0;
		while (n_cases < MAX_CASES && case_mem[n_cases*FIELDS] != 0) begin
			msgs += case_mem[n_cases*FIELDS] + case_mem[n_cases*FIELDS+1];
			n_cases++;
		end
		if (n_cases == 0) begin
			$display("no test cases could be read from msg_cases.txt");
			err_cnt++;
		end
		cycle_limit = 20 * msgs + 100;
		repeat (3) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		check_value(o_done, 0, "o_done after reset");
		check_value(o_err_0, 0, "o_err_0 after reset");
		check_value(o_err_1, 0, "o_err_1 after reset");
		check_value(o_total, 0, "o_total after reset");
		check_value(o_seg_hi, seg_expect(4'h0), "o_seg_hi after reset");
		check_value(o_seg_lo, seg_expect(4'h0), "o_seg_lo after reset");
		for (k = 0; k < n_cases; k++) begin
			run_case(k);
		end
		$display("cases %0d checks %0d errors %0d", n_cases, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- msg_cases.txt
// columns, all hex: count_0 count_1 corrupt_0 corrupt_1 hold err_0 err_1 total
// hold 0 means none, 1 means random checker stalls
05 09 0 0 0 0 0 0e  // clean, unequal lengths
01 03 0 0 0 0 0 04  // shortest source 0 run
04 06 1 0 0 1 0 0a  // source 0 corrupted
07 03 0 1 0 0 1 0a  // source 1 corrupted
0c 05 0 0 1 0 0 11  // random stalls
03 0b 0 0 1 0 0 0e  // random stalls, source 1 longer
3f 3f 0 0 0 0 0 7e  // longest runs
06 06 1 0 1 1 0 0c  // corruption under stalls
0a 01 0 0 0 0 0 0b  // clean restart after an error run
03 04 0 1 1 0 1 07  // source 1 corrupted under stalls
08 02 0 0 0 0 0 0a  // clean restart again

//--- flist.f
+incdir+.
msg_pkg.sv
msg_source.sv
msg_merge_2to1.sv
msg_checker.sv
seg_display.sv
msg_test_top.sv
tb_msg_test_top.sv
